/* build.f */
verilog/mem_pkg.sv
verilog/mem_request.sv
verilog/load_format.sv
verilog/mem_wb_reg.sv
verilog/mem_stage.sv
sim/mem_stage_props.sv
sim/tb_mem_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the mem_stage testbench with Verilator, runs it, and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_mem_stage \
    -f build.f -o tb_mem_stage \
    && ./obj_dir/tb_mem_stage > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

/* sim/mem_stage_props.sv */
`timescale 1ns/1ns

module mem_stage_props import mem_pkg::*; (
    input logic     clk,
    input logic     rst_n_i,
    input ex_mem_t  ex_i,                            // op from execute
    input ram_req_t ram_o,                           // request under check
    input wb_t      wb_o                             // registered writeback
);

    // lanes only with the chip enabled
    sel_needs_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ram_o.sel != SEL_NONE) |-> ram_o.ce)
        else $error("byte select active while ram_o.ce is low");

    we_needs_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
        ram_o.we |-> ram_o.ce)
        else $error("write enable active while ram_o.ce is low");

    // partial word ops always address the whole word
    partial_ops_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ex_i.op inside {OP_LWL, OP_LWR, OP_SWL, OP_SWR}) |-> (ram_o.addr[1:0] == 2'b00))
        else $error("lwl/lwr/swl/swr address not word aligned");

    wb_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !wb_o.reg_we)
        else $error("wb_o.reg_we high in the first cycle after reset");

endmodule

bind mem_stage mem_stage_props props0 (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .ex_i    (ex_i),
    .ram_o   (ram_o),
    .wb_o    (wb_o)
);

/* sim/tb_mem_stage.sv */
`timescale 1ns/1ns

module tb_mem_stage
    import mem_pkg::*;
();

    localparam int HALF_PERIOD  = 50;                // 100 ns clock
    localparam int RESET_CYCLES = 16;
    localparam int TEST_CYCLES  = 2000;
    localparam int MARGIN       = 50;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + TEST_CYCLES + MARGIN;
    localparam int RAM_WORDS    = 64;                // 256 byte window
    localparam int DIRECTED_OPS = 5;

    logic              clk;
    logic              rst_n_i;
    ex_mem_t           ex_i;
    logic [DATA_W-1:0] ram_rdata_i;
    ram_req_t          ram_o;
    wb_t               wb_o;

    logic [DATA_W-1:0] ram [RAM_WORDS];              // ram behind the dut
    logic [DATA_W-1:0] ref_mem [RAM_WORDS];          // model image of the same ram
    logic              ref_link;                     // model ll/sc reservation
    ram_req_t          last_req;                     // request of the op in flight
    mem_op_e           last_op;
    wb_t               exp_wb_q;                     // due on wb_o next cycle
    int                errors = 0;
    int                ops = 0;
    int                cycles = 0;

    mem_stage dut0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_i        (ex_i),
        .ram_rdata_i (ram_rdata_i),
        .ram_o       (ram_o),
        .wb_o        (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // every byte differs with the word index
    function automatic logic [DATA_W-1:0] fill_word(input logic [5:0] idx);
        return {2'b10, idx, 8'hc3 ^ {idx, 2'b01}, ~{2'b00, idx}, {idx, idx[5:4]}};
    endfunction

    function automatic logic [DATA_W-1:0] lane_mask(input logic [SEL_W-1:0] sel);
        logic [DATA_W-1:0] m;
        for (int l = 0; l < SEL_W; l++) begin
            m[l*BYTE_W +: BYTE_W] = {BYTE_W{sel[l]}};
        end
        return m;
    endfunction

    // same-cycle read, lane writes at the edge, loaded while in reset
    assign ram_rdata_i = ram[ram_o.addr[7:2]];

    always @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                ram[i] <= fill_word(6'(i));
            end
        end else if (ram_o.ce && ram_o.we) begin
            for (int l = 0; l < SEL_W; l++) begin
                if (ram_o.sel[l]) begin
                    ram[ram_o.addr[7:2]][l*BYTE_W +: BYTE_W] <= ram_o.wdata[l*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // expected request, big-endian offset n maps to lane 3-n
    function automatic ram_req_t model_req(input ex_mem_t ex, input logic link);
        ram_req_t   r;
        logic [1:0] n;
        n      = ex.addr[1:0];
        r      = '0;
        r.addr = ex.addr;
        case (ex.op)
            OP_LB, OP_LBU: begin
                r.ce  = 1'b1;
                r.sel = 4'b1000 >> n;
            end
            OP_LH, OP_LHU: begin
                r.ce  = 1'b1;                        // enabled even when odd
                r.sel = (n == 2'd0) ? SEL_H0 : (n == 2'd2) ? SEL_H1 : SEL_NONE;
            end
            OP_LW: begin
                r.ce  = 1'b1;
                r.sel = (n == 2'd0) ? SEL_ALL : SEL_NONE;
            end
            OP_LL: begin
                r.ce  = 1'b1;
                r.sel = SEL_ALL;
            end
            OP_LWL, OP_LWR: begin
                r.ce        = 1'b1;
                r.addr[1:0] = 2'b00;
                r.sel       = SEL_ALL;
            end
            OP_SB: begin
                r.ce    = 1'b1;
                r.we    = 1'b1;
                r.sel   = 4'b1000 >> n;
                r.wdata = {4{ex.rt_data[7:0]}};
            end
            OP_SH: begin
                r.ce    = 1'b1;
                r.we    = 1'b1;
                r.sel   = (n == 2'd0) ? SEL_H0 : (n == 2'd2) ? SEL_H1 : SEL_NONE;
                r.wdata = {2{ex.rt_data[15:0]}};
            end
            OP_SW: begin
                r.ce    = 1'b1;
                r.we    = 1'b1;
                r.sel   = (n == 2'd0) ? SEL_ALL : SEL_NONE;
                r.wdata = ex.rt_data;
            end
            OP_SWL: begin
                r.ce        = 1'b1;
                r.we        = 1'b1;
                r.addr[1:0] = 2'b00;
                r.sel       = SEL_ALL >> n;          // low 4-n lanes
                r.wdata     = ex.rt_data >> (8 * n);
            end
            OP_SWR: begin
                r.ce        = 1'b1;
                r.we        = 1'b1;
                r.addr[1:0] = 2'b00;
                r.sel       = SEL_ALL << (3 - n);    // high n+1 lanes
                r.wdata     = ex.rt_data << (8 * (3 - n));
            end
            OP_SC: begin
                if (link) begin
                    r.ce    = 1'b1;
                    r.we    = 1'b1;
                    r.sel   = SEL_ALL;
                    r.wdata = ex.rt_data;
                end
            end
            default: begin
            end
        endcase
        return r;
    endfunction

    // expected writeback from the model ram word
    function automatic wb_t model_wb(input ex_mem_t ex, input logic link,
                                     input logic [DATA_W-1:0] word);
        wb_t               w;
        logic [1:0]        n;
        logic [7:0]        b;
        logic [15:0]       h;
        logic [DATA_W-1:0] keep;
        n        = ex.addr[1:0];
        b        = 8'(word >> (8 * (3 - n)));
        h        = 16'(word >> (16 - 8 * n));      // only even n is used
        w.waddr  = ex.waddr;
        w.reg_we = ex.reg_we;
        w.wdata  = ex.alu_res;
        case (ex.op)
            OP_LB:  w.wdata = {{24{b[7]}}, b};
            OP_LBU: w.wdata = {24'h0, b};
            OP_LH:  w.wdata = n[0] ? '0 : {{16{h[15]}}, h};
            OP_LHU: w.wdata = n[0] ? '0 : {16'h0, h};
            OP_LW:  w.wdata = (n == 2'd0) ? word : '0;
            OP_LL:  w.wdata = word;
            OP_LWL: begin
                keep    = (32'h1 << (8 * n)) - 32'h1;          // rt bytes left over
                w.wdata = (word << (8 * n)) | (ex.rt_data & keep);
            end
            OP_LWR: begin
                keep    = ~(32'hffff_ffff >> (8 * (3 - n)));
                w.wdata = (word >> (8 * (3 - n))) | (ex.rt_data & keep);
            end
            OP_SC:  w.wdata = {31'h0, link};
            default: begin
            end
        endcase
        return w;
    endfunction

    function automatic ex_mem_t make_ex(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                                        input logic [DATA_W-1:0] rt);
        ex_mem_t e;
        e.op      = op;
        e.addr    = addr;
        e.rt_data = rt;
        e.alu_res = $urandom();
        e.waddr   = 5'($urandom());
        e.reg_we  = 1'b1;
        return e;
    endfunction

    function automatic ex_mem_t random_ex();
        ex_mem_t e;
        e         = make_ex(mem_op_e'(4'($urandom_range(14, 0))),
                            {24'h0, 8'($urandom_range(255, 0))}, $urandom());
        e.reg_we  = 1'($urandom());
        return e;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_req(input ram_req_t exp);
        logic [DATA_W-1:0] m;
        m = (ex_i.op inside {OP_SB, OP_SH}) ? '1 : lane_mask(exp.sel);    // sb/sh fill all lanes
        check_field("ram_o.ce", 32'(ram_o.ce), 32'(exp.ce));
        check_field("ram_o.we", 32'(ram_o.we), 32'(exp.we));
        if (exp.ce) begin
            check_field("ram_o.addr", ram_o.addr, exp.addr);
            check_field("ram_o.sel", 32'(ram_o.sel), 32'(exp.sel));
        end
        if (exp.ce && exp.we) begin
            check_field("ram_o.wdata", ram_o.wdata & m, exp.wdata & m);
        end
    endtask

    task automatic compare_wb(input wb_t exp);
        check_field("wb_o.waddr", 32'(wb_o.waddr), 32'(exp.waddr));
        check_field("wb_o.reg_we", 32'(wb_o.reg_we), 32'(exp.reg_we));
        check_field("wb_o.wdata", wb_o.wdata, exp.wdata);
    endtask

    // the edge retires the previous op in the model too
    task automatic commit_model();
        if (last_req.ce && last_req.we) begin
            for (int l = 0; l < SEL_W; l++) begin
                if (last_req.sel[l]) begin
                    ref_mem[last_req.addr[7:2]][l*BYTE_W +: BYTE_W] =
                        last_req.wdata[l*BYTE_W +: BYTE_W];
                end
            end
        end
        if (last_op == OP_LL) begin
            ref_link = 1'b1;
        end else if (last_op == OP_SC && ref_link) begin
            ref_link = 1'b0;                         // reservation used up
        end
    endtask

    // drive after the edge, check at the falling edge
    task automatic run_op(input ex_mem_t ex);
        ram_req_t req;
        wb_t      wb;
        @(posedge clk);
        commit_model();
        #1;
        ex_i = ex;
        @(negedge clk);
        req = model_req(ex_i, ref_link);
        wb  = model_wb(ex_i, ref_link, ref_mem[ex_i.addr[7:2]]);
        compare_req(req);
        compare_wb(exp_wb_q);                        // op from one cycle back
        exp_wb_q = wb;
        last_req = req;
        last_op  = ex_i.op;
        ops++;
    endtask

    initial begin
        void'($urandom(32'hc01c));
        rst_n_i  = 1'b0;
        ex_i     = '0;
        ref_link = 1'b0;
        last_req = '0;
        last_op  = OP_NONE;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ref_mem[i] = fill_word(6'(i));
        end

        repeat (RESET_CYCLES) begin                  // random ops must stay quiet
            @(posedge clk);
            #1;
            ex_i = random_ex();
            @(negedge clk);
            check_field("ram_o.ce", 32'(ram_o.ce), 32'h0);
            check_field("ram_o.we", 32'(ram_o.we), 32'h0);
            check_field("wb_o.reg_we", 32'(wb_o.reg_we), 32'h0);
        end

        @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        ex_i    = '0;                                // bubble
        @(negedge clk);
        check_field("wb_o.reg_we", 32'(wb_o.reg_we), 32'h0);
        exp_wb_q = model_wb(ex_i, ref_link, ref_mem[ex_i.addr[7:2]]);

        run_op(make_ex(OP_SC, 32'h0000_0044, 32'h1234_5678));  // no ll since reset
        run_op(make_ex(OP_LL, 32'h0000_0080, 32'h0));
        run_op(make_ex(OP_SC, 32'h0000_0080, 32'hcafe_f00d));
        run_op(make_ex(OP_SC, 32'h0000_0080, 32'h0bad_0bad));  // link already gone
        run_op(make_ex(OP_LW, 32'h0000_0080, 32'h0));

        repeat (TEST_CYCLES - DIRECTED_OPS - 1) begin
            run_op(random_ex());
        end
        run_op(make_ex(OP_NONE, 32'h0, 32'h0));      // flushes the last writeback

        $display("ops checked: %0d, errors: %0d", ops, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/load_format.sv */
`timescale 1ns/1ns

module load_format import mem_pkg::*; (
    input  ex_mem_t           ex_i,                  // op from execute
    input  logic [DATA_W-1:0] ram_rdata_i,           // word at ram_o.addr
    input  logic              sc_ok_i,               // sc status from request
    output wb_t               wb_o                   // unregistered writeback
);

    logic [1:0]          lo;                         // byte offset in word
    logic [BYTE_W-1:0]   rd_byte;                    // addressed byte
    logic [2*BYTE_W-1:0] rd_half;                    // addressed half
    logic                half_ok;                    // even offset
    logic [DATA_W-1:0]   rt;                         // old rt for lwl/lwr

    assign lo      = ex_i.addr[1:0];
    assign rt      = ex_i.rt_data;
    assign half_ok = ~lo[0];
    assign rd_half = lo[1] ? ram_rdata_i[15:0] : ram_rdata_i[31:16];

    // offset 0 sits in the msb lane
    always_comb begin
        case (lo)
            2'd0:    rd_byte = ram_rdata_i[31:24];
            2'd1:    rd_byte = ram_rdata_i[23:16];
            2'd2:    rd_byte = ram_rdata_i[15:8];
            default: rd_byte = ram_rdata_i[7:0];
        endcase
    end

    always_comb begin
        wb_o.waddr  = ex_i.waddr;                    // passes straight through
        wb_o.reg_we = ex_i.reg_we;
        wb_o.wdata  = ex_i.alu_res;                  // none and stores
        case (ex_i.op)
            OP_LB: begin
                wb_o.wdata = {{(DATA_W-BYTE_W){rd_byte[BYTE_W-1]}}, rd_byte};
            end
            OP_LBU: begin
                wb_o.wdata = {{(DATA_W-BYTE_W){1'b0}}, rd_byte};
            end
            OP_LH: begin                             // misaligned gives zero
                wb_o.wdata = half_ok ?
                    {{(DATA_W-2*BYTE_W){rd_half[2*BYTE_W-1]}}, rd_half} : '0;
            end
            OP_LHU: begin
                wb_o.wdata = half_ok ? {{(DATA_W-2*BYTE_W){1'b0}}, rd_half} : '0;
            end
            OP_LW: begin
                wb_o.wdata = (lo == 2'd0) ? ram_rdata_i : '0;
            end
            OP_LL: begin
                wb_o.wdata = ram_rdata_i;
            end
            OP_LWL: begin
                case (lo)                            // low 4-n mem bytes to top of rt
                    2'd0:    wb_o.wdata = ram_rdata_i;
                    2'd1:    wb_o.wdata = {ram_rdata_i[23:0], rt[7:0]};
                    2'd2:    wb_o.wdata = {ram_rdata_i[15:0], rt[15:0]};
                    default: wb_o.wdata = {ram_rdata_i[7:0], rt[23:0]};
                endcase
            end
            OP_LWR: begin
                case (lo)                            // top n+1 mem bytes to bottom of rt
                    2'd0:    wb_o.wdata = {rt[31:8], ram_rdata_i[31:24]};
                    2'd1:    wb_o.wdata = {rt[31:16], ram_rdata_i[31:16]};
                    2'd2:    wb_o.wdata = {rt[31:24], ram_rdata_i[31:8]};
                    default: wb_o.wdata = ram_rdata_i;
                endcase
            end
            OP_SC: begin
                wb_o.wdata = {{(DATA_W-1){1'b0}}, sc_ok_i};     // 1 on success
            end
            default: begin
            end
        endcase
    end

endmodule

/* verilog/mem_pkg.sv */
package mem_pkg;

    localparam int DATA_W     = 32;                  // gpr and ram word
    localparam int ADDR_W     = 32;                  // byte address
    localparam int REG_ADDR_W = 5;                   // gpr index
    localparam int SEL_W      = 4;                   // byte lanes per word
    localparam int BYTE_W     = 8;                   // lane width

    // big-endian lanes: sel[3] is byte address 0 and carries the msb
    localparam logic [SEL_W-1:0] SEL_NONE = 4'b0000; // no lane
    localparam logic [SEL_W-1:0] SEL_ALL  = 4'b1111; // full word
    localparam logic [SEL_W-1:0] SEL_B0   = 4'b1000; // byte at offset 0
    localparam logic [SEL_W-1:0] SEL_B1   = 4'b0100; // byte at offset 1
    localparam logic [SEL_W-1:0] SEL_B2   = 4'b0010; // byte at offset 2
    localparam logic [SEL_W-1:0] SEL_B3   = 4'b0001; // byte at offset 3
    localparam logic [SEL_W-1:0] SEL_H0   = 4'b1100; // upper half, offset 0
    localparam logic [SEL_W-1:0] SEL_H1   = 4'b0011; // lower half, offset 2

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,                              // alu result only
        OP_LB   = 4'd1,
        OP_LBU  = 4'd2,
        OP_LH   = 4'd3,
        OP_LHU  = 4'd4,
        OP_LW   = 4'd5,
        OP_LWL  = 4'd6,                              // unaligned left
        OP_LWR  = 4'd7,                              // unaligned right
        OP_LL   = 4'd8,                              // load linked
        OP_SB   = 4'd9,
        OP_SH   = 4'd10,
        OP_SW   = 4'd11,
        OP_SWL  = 4'd12,
        OP_SWR  = 4'd13,
        OP_SC   = 4'd14                              // store conditional
    } mem_op_e;

    // operation handed over from execute
    typedef struct packed {
        mem_op_e               op;                   // memory op code
        logic [ADDR_W-1:0]     addr;                 // effective address
        logic [DATA_W-1:0]     rt_data;              // old rt, store source
        logic [DATA_W-1:0]     alu_res;              // non-memory result
        logic [REG_ADDR_W-1:0] waddr;                // dest register
        logic                  reg_we;               // dest write enable
    } ex_mem_t;

    // data ram request, answered in the same cycle
    typedef struct packed {
        logic              ce;                       // chip enable
        logic              we;                       // write enable
        logic [ADDR_W-1:0] addr;                     // byte address
        logic [SEL_W-1:0]  sel;                      // byte lanes
        logic [DATA_W-1:0] wdata;                    // lane-steered store data
    } ram_req_t;

    // writeback toward the register file
    typedef struct packed {
        logic [REG_ADDR_W-1:0] waddr;                // dest register
        logic                  reg_we;               // dest write enable
        logic [DATA_W-1:0]     wdata;                // result word
    } wb_t;

endpackage

/* verilog/mem_request.sv */
`timescale 1ns/1ns

module mem_request import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  ex_mem_t  ex_i,                           // op from execute
    output ram_req_t ram_o,                          // data ram request
    output logic     sc_ok_o                         // sc goes ahead
);

    logic [1:0]        lo;                           // byte offset in word
    logic              link_q;                       // ll/sc reservation
    logic              ce;
    logic              we;
    logic [SEL_W-1:0]  sel;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [ADDR_W-1:0] addr_al;                      // word aligned address

    // single byte lane for offset n is lane 3-n
    function automatic logic [SEL_W-1:0] byte_sel(input logic [1:0] off);
        logic [SEL_W-1:0] s;
        case (off)
            2'd0:    s = SEL_B0;
            2'd1:    s = SEL_B1;
            2'd2:    s = SEL_B2;
            default: s = SEL_B3;
        endcase
        return s;
    endfunction

    // half-word lanes, odd offset selects nothing
    function automatic logic [SEL_W-1:0] half_sel(input logic [1:0] off);
        logic [SEL_W-1:0] s;
        case (off)
            2'd0:    s = SEL_H0;
            2'd2:    s = SEL_H1;
            default: s = SEL_NONE;
        endcase
        return s;
    endfunction

    assign lo      = ex_i.addr[1:0];
    assign addr_al = {ex_i.addr[ADDR_W-1:2], 2'b00};
    assign sc_ok_o = (ex_i.op == OP_SC) && link_q;   // needs a live reservation

    always_comb begin
        ce    = 1'b0;                                // default is no access
        we    = 1'b0;
        sel   = SEL_NONE;
        addr  = ex_i.addr;
        wdata = '0;
        case (ex_i.op)
            OP_LB, OP_LBU: begin
                ce  = 1'b1;
                sel = byte_sel(lo);
            end
            OP_LH, OP_LHU: begin
                ce  = 1'b1;                          // ce stays up when misaligned
                sel = half_sel(lo);
            end
            OP_LW: begin
                ce  = 1'b1;
                sel = (lo == 2'd0) ? SEL_ALL : SEL_NONE;
            end
            OP_LL: begin
                ce  = 1'b1;                          // no alignment check
                sel = SEL_ALL;
            end
            OP_LWL, OP_LWR: begin
                ce   = 1'b1;
                addr = addr_al;                      // whole word, merge later
                sel  = SEL_ALL;
            end
            OP_SB: begin
                ce    = 1'b1;
                we    = 1'b1;
                sel   = byte_sel(lo);
                wdata = {SEL_W{ex_i.rt_data[BYTE_W-1:0]}};      // byte on every lane
            end
            OP_SH: begin
                ce    = 1'b1;
                we    = 1'b1;
                sel   = half_sel(lo);
                wdata = {2{ex_i.rt_data[2*BYTE_W-1:0]}};        // half on both halves
            end
            OP_SW: begin
                ce    = 1'b1;
                we    = 1'b1;
                sel   = (lo == 2'd0) ? SEL_ALL : SEL_NONE;
                wdata = ex_i.rt_data;
            end
            OP_SWL: begin
                ce   = 1'b1;
                we   = 1'b1;
                addr = addr_al;
                case (lo)                            // top 4-n rt bytes to low lanes
                    2'd0: begin
                        sel   = SEL_ALL;
                        wdata = ex_i.rt_data;
                    end
                    2'd1: begin
                        sel   = 4'b0111;
                        wdata = {8'b0, ex_i.rt_data[31:8]};
                    end
                    2'd2: begin
                        sel   = 4'b0011;
                        wdata = {16'b0, ex_i.rt_data[31:16]};
                    end
                    default: begin
                        sel   = 4'b0001;
                        wdata = {24'b0, ex_i.rt_data[31:24]};
                    end
                endcase
            end
            OP_SWR: begin
                ce   = 1'b1;
                we   = 1'b1;
                addr = addr_al;
                case (lo)                            // bottom n+1 rt bytes to high lanes
                    2'd0: begin
                        sel   = 4'b1000;
                        wdata = {ex_i.rt_data[7:0], 24'b0};
                    end
                    2'd1: begin
                        sel   = 4'b1100;
                        wdata = {ex_i.rt_data[15:0], 16'b0};
                    end
                    2'd2: begin
                        sel   = 4'b1110;
                        wdata = {ex_i.rt_data[23:0], 8'b0};
                    end
                    default: begin
                        sel   = SEL_ALL;
                        wdata = ex_i.rt_data;
                    end
                endcase
            end
            OP_SC: begin
                if (link_q) begin                    // failed sc issues nothing
                    ce    = 1'b1;
                    we    = 1'b1;
                    sel   = SEL_ALL;
                    wdata = ex_i.rt_data;
                end
            end
            default: begin
            end
        endcase
    end

    assign ram_o.ce    = ce & rst_n_i;               // quiet while in reset
    assign ram_o.we    = we & rst_n_i;
    assign ram_o.addr  = addr;
    assign ram_o.sel   = sel;
    assign ram_o.wdata = wdata;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            link_q <= 1'b0;
        end else if (ex_i.op == OP_LL) begin
            link_q <= 1'b1;                          // ll takes the reservation
        end else if (sc_ok_o) begin
            link_q <= 1'b0;                          // consumed by sc
        end
    end

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  ex_mem_t           ex_i,                  // op from execute
    input  logic [DATA_W-1:0] ram_rdata_i,           // same-cycle ram data
    output ram_req_t          ram_o,                 // combinational request
    output wb_t               wb_o                   // registered writeback
);

    logic sc_ok;                                     // sc with live link
    wb_t  wb_next;                                   // formatted, pre-register

    // address, lanes, store data, link bit
    mem_request u_mem_request (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ex_i    (ex_i),
        .ram_o   (ram_o),
        .sc_ok_o (sc_ok)
    );

    // load extension and merge
    load_format u_load_format (
        .ex_i        (ex_i),
        .ram_rdata_i (ram_rdata_i),
        .sc_ok_i     (sc_ok),
        .wb_o        (wb_next)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (wb_next),
        .wb_o    (wb_o)
    );

endmodule

/* verilog/mem_wb_reg.sv */
`timescale 1ns/1ns

module mem_wb_reg import mem_pkg::*; (
    input  logic clk,
    input  logic rst_n_i,
    input  wb_t  wb_i,                               // from load_format
    output wb_t  wb_o                                // to writeback stage
);

    // one cycle, no stall, new op every edge
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_o <= '0;                              // reg_we low after reset
        end else begin
            wb_o <= wb_i;
        end
    end

endmodule
